//--- hdl/VideoTxCsr_consts.svh
// widths, address map values and reset values
// shared by the video TX CSR block
`ifndef VIDEO_TX_CSR_CONSTS_SVH
`define VIDEO_TX_CSR_CONSTS_SVH

//----------------------------------------------------------------------
// slave bus
//----------------------------------------------------------------------
`define CSR_BUS_W		32
`define CSR_WSTB_BIT	30		// write strobe, address bit
`define CSR_BLK_HI		23		// block select field
`define CSR_BLK_LO		16
`define CSR_BLOCK_MAP	8'h04	// this CSR block
`define CSR_OFS_W		16

//----------------------------------------------------------------------
// register field widths
//----------------------------------------------------------------------
`define DMA_ADRS_W		19
`define COLOR_W			32
`define HPOS_W			11
`define VPOS_W			11
`define MCU_DQ_W		24		// panel data bus
`define MCU_IM_W		4		// panel interface mode
`define SCENE_TIM_W		7

// map size after reset, 480/16 by 272/16 tiles
`define MAP_X_RST		8'd30
`define MAP_Y_RST		8'd17

`endif

//--- hdl/CsrMapPkg.sv
// register offset enum and the decoded bus access struct
`default_nettype none
`include "VideoTxCsr_consts.svh"

package CsrMapPkg;

	typedef enum logic [`CSR_OFS_W-1:0]
	{
		// dma
		OFS_DMA_EN		= 'h004,
		OFS_DMA_CYC		= 'h008,
		OFS_DMA_START	= 'h00C,
		OFS_DMA_END		= 'h010,
		OFS_DMA_ADD		= 'h014,
		OFS_VSG_RST		= 'h020,
		// mcu panel bus
		OFS_MCU_DQ		= 'h050,
		OFS_MCU_WRX		= 'h051,
		OFS_MCU_DCX		= 'h052,
		OFS_MCU_RDX		= 'h053,
		OFS_MCU_CSX		= 'h054,
		OFS_MCU_RST		= 'h055,
		OFS_MCU_IM		= 'h056,
		OFS_MCU_GATE	= 'h057,
		OFS_MCU_CONV_RST	= 'h058,
		OFS_MAP			= 'h100,
		// scene fader
		OFS_SCN_COLOR	= 'h300,
		OFS_SCN_TIM		= 'h301,
		OFS_SCN_FLAGS	= 'h302,
		OFS_SCN_ALPHA	= 'h303,	// read only
		OFS_PDP_H		= 'h400,	// read only
		OFS_PDP_V		= 'h401,
		OFS_NONE		= 'hFFFF
	} csrOfsE;

	typedef struct packed
	{
		logic					wEn;
		csrOfsE					wOfs;
		logic [`CSR_BUS_W-1:0]	wData;
	} csrAccessT;

endpackage

`default_nettype wire

//--- hdl/VideoCtrlPkg.sv
// control groups driven to the video pipeline
// and the pixel position coming back from it
`default_nettype none
`include "VideoTxCsr_consts.svh"

package VideoCtrlPkg;

	typedef struct packed
	{
		logic						enable;
		logic						cycleEnable;	// reload enable on done
		logic [`DMA_ADRS_W-1:0]		adrsStart;
		logic [`DMA_ADRS_W-1:0]		adrsEnd;
		logic [`DMA_ADRS_W-1:0]		adrsAdd;
	} dmaCtrlT;

	// mcu mode panel pins, driven by software
	typedef struct packed
	{
		logic [`MCU_DQ_W-1:0]		dq;
		logic						wrx;
		logic						dcx;
		logic						rdx;
		logic						csx;
		logic						rst;
		logic [`MCU_IM_W-1:0]		im;
		logic						gate;
		logic						converterRst;
	} mcuBusT;

	typedef struct packed
	{
		logic [`COLOR_W-1:0]		color;
		logic [`SCENE_TIM_W-1:0]	frameTiming;
		logic						addEn;	// fade in
		logic						subEn;	// fade out
		logic						rst;
	} sceneCtrlT;

	typedef struct packed
	{
		logic [7:0]	xSize;	// tiles, max 255
		logic [7:0]	ySize;
	} mapSizeT;

	typedef struct packed
	{
		logic [`HPOS_W-1:0]	hpos;
		logic [`VPOS_W-1:0]	vpos;
	} pdpPosT;

endpackage

`default_nettype wire

//--- hdl/CsrAdrsDecode.sv
// slave address decode into write access and read select
`default_nettype none
`include "VideoTxCsr_consts.svh"

module CsrAdrsDecode
(
	input	wire [`CSR_BUS_W-1:0]		iSUsiAdrs,
	input	wire [`CSR_BUS_W-1:0]		iSUsiWd,
	output	CsrMapPkg::csrAccessT		csrAccess,
	output	CsrMapPkg::csrOfsE			readSel
);

	logic [`CSR_OFS_W-1:0]	ofs;
	CsrMapPkg::csrOfsE		ofsSel;
	logic					blkHit;

	assign ofs		= iSUsiAdrs[`CSR_OFS_W-1:0];
	assign blkHit	= (iSUsiAdrs[`CSR_BLK_HI:`CSR_BLK_LO] == `CSR_BLOCK_MAP);

	// anything outside the kept map falls to OFS_NONE
	always_comb
	begin
		case (ofs)
			CsrMapPkg::OFS_DMA_EN, CsrMapPkg::OFS_DMA_CYC, CsrMapPkg::OFS_DMA_START,
			CsrMapPkg::OFS_DMA_END, CsrMapPkg::OFS_DMA_ADD, CsrMapPkg::OFS_VSG_RST,
			CsrMapPkg::OFS_MCU_DQ, CsrMapPkg::OFS_MCU_WRX, CsrMapPkg::OFS_MCU_DCX,
			CsrMapPkg::OFS_MCU_RDX, CsrMapPkg::OFS_MCU_CSX, CsrMapPkg::OFS_MCU_RST,
			CsrMapPkg::OFS_MCU_IM, CsrMapPkg::OFS_MCU_GATE, CsrMapPkg::OFS_MCU_CONV_RST,
			CsrMapPkg::OFS_MAP, CsrMapPkg::OFS_SCN_COLOR, CsrMapPkg::OFS_SCN_TIM,
			CsrMapPkg::OFS_SCN_FLAGS, CsrMapPkg::OFS_SCN_ALPHA, CsrMapPkg::OFS_PDP_H,
			CsrMapPkg::OFS_PDP_V:
				ofsSel = CsrMapPkg::csrOfsE'(ofs);
			default:
				ofsSel = CsrMapPkg::OFS_NONE;
		endcase
	end

	assign csrAccess.wEn	= iSUsiAdrs[`CSR_WSTB_BIT] & blkHit & (ofsSel != CsrMapPkg::OFS_NONE);
	assign csrAccess.wOfs	= ofsSel;
	assign csrAccess.wData	= iSUsiWd;

	// read select ignores block and strobe
	assign readSel = ofsSel;

endmodule

`default_nettype wire

//--- hdl/DmaCsrRegs.sv
// DMA control registers with the done-driven auto cycle
`default_nettype none
`include "VideoTxCsr_consts.svh"

module DmaCsrRegs
(
	input	wire						iSCLK,
	input	wire						iSRST,
	input	wire CsrMapPkg::csrAccessT	csrAccess,
	input	wire						iDmaDone,
	output	VideoCtrlPkg::dmaCtrlT		dmaCtrl
);

	logic	enWr;

	assign enWr = csrAccess.wEn && (csrAccess.wOfs == CsrMapPkg::OFS_DMA_EN);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			dmaCtrl.enable		<= 1'b0;
			dmaCtrl.cycleEnable	<= 1'b0;
			dmaCtrl.adrsStart	<= '0;
			dmaCtrl.adrsEnd		<= '1;	// full range
			dmaCtrl.adrsAdd		<= '0;
		end
		else
		begin
			// done beats a write to the enable register
			if (iDmaDone)
				dmaCtrl.enable <= dmaCtrl.cycleEnable;
			else if (enWr)
				dmaCtrl.enable <= csrAccess.wData[0];

			if (csrAccess.wEn)
			begin
				case (csrAccess.wOfs)
					CsrMapPkg::OFS_DMA_CYC:
						dmaCtrl.cycleEnable <= csrAccess.wData[0];
					CsrMapPkg::OFS_DMA_START:
						dmaCtrl.adrsStart <= csrAccess.wData[`DMA_ADRS_W-1:0];
					CsrMapPkg::OFS_DMA_END:
						dmaCtrl.adrsEnd <= csrAccess.wData[`DMA_ADRS_W-1:0];
					CsrMapPkg::OFS_DMA_ADD:
						dmaCtrl.adrsAdd <= csrAccess.wData[`DMA_ADRS_W-1:0];
					default:
						;	// other bank or enable
				endcase
			end
		end
	end

	//----------------------------------------------------------------------
	// checks
	//----------------------------------------------------------------------
	// enable only comes up from software or from an auto cycle reload
	assert property (@(posedge iSCLK) disable iff (iSRST)
		$rose(dmaCtrl.enable) |-> $past(iDmaDone || enWr))
		else $error("dma enable rose without write or done");

endmodule

`default_nettype wire

//--- hdl/VideoCsrRegs.sv
// VSG reset, MCU panel bus, map size and scene fader registers
`default_nettype none
`include "VideoTxCsr_consts.svh"

module VideoCsrRegs
(
	input	wire						iSCLK,
	input	wire						iSRST,
	input	wire CsrMapPkg::csrAccessT	csrAccess,
	output	logic						vsgRst,
	output	VideoCtrlPkg::mcuBusT		mcuBus,
	output	VideoCtrlPkg::mapSizeT		mapSize,
	output	VideoCtrlPkg::sceneCtrlT	sceneCtrl
);

	logic [`CSR_BUS_W-1:0]	wd;

	assign wd = csrAccess.wData;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			vsgRst					<= 1'b1;	// sync gen held in reset
			mcuBus.dq				<= '0;
			mcuBus.wrx				<= 1'b0;
			mcuBus.dcx				<= 1'b0;
			mcuBus.rdx				<= 1'b0;
			mcuBus.csx				<= 1'b1;	// chip deselected
			mcuBus.rst				<= 1'b0;
			mcuBus.im				<= '0;
			mcuBus.gate				<= 1'b1;	// mcu stream by default
			mcuBus.converterRst		<= 1'b1;
			mapSize.xSize			<= `MAP_X_RST;
			mapSize.ySize			<= `MAP_Y_RST;
			sceneCtrl.color			<= '0;
			sceneCtrl.frameTiming	<= '0;
			sceneCtrl.addEn			<= 1'b0;
			sceneCtrl.subEn			<= 1'b0;
			sceneCtrl.rst			<= 1'b1;
		end
		else if (csrAccess.wEn)
		begin
			case (csrAccess.wOfs)
				CsrMapPkg::OFS_VSG_RST:			vsgRst <= wd[0];
				CsrMapPkg::OFS_MCU_DQ:			mcuBus.dq <= wd[`MCU_DQ_W-1:0];
				CsrMapPkg::OFS_MCU_WRX:			mcuBus.wrx <= wd[0];
				CsrMapPkg::OFS_MCU_DCX:			mcuBus.dcx <= wd[0];
				CsrMapPkg::OFS_MCU_RDX:			mcuBus.rdx <= wd[0];
				CsrMapPkg::OFS_MCU_CSX:			mcuBus.csx <= wd[0];
				CsrMapPkg::OFS_MCU_RST:			mcuBus.rst <= wd[0];
				CsrMapPkg::OFS_MCU_IM:			mcuBus.im <= wd[`MCU_IM_W-1:0];
				CsrMapPkg::OFS_MCU_GATE:		mcuBus.gate <= wd[0];
				CsrMapPkg::OFS_MCU_CONV_RST:	mcuBus.converterRst <= wd[0];
				CsrMapPkg::OFS_MAP:
				begin
					mapSize.xSize <= wd[15:8];
					mapSize.ySize <= wd[7:0];
				end
				CsrMapPkg::OFS_SCN_COLOR:		sceneCtrl.color <= wd[`COLOR_W-1:0];
				CsrMapPkg::OFS_SCN_TIM:			sceneCtrl.frameTiming <= wd[`SCENE_TIM_W-1:0];
				// the three fader flags go together
				CsrMapPkg::OFS_SCN_FLAGS:
				begin
					sceneCtrl.addEn	<= wd[0];
					sceneCtrl.subEn	<= wd[1];
					sceneCtrl.rst	<= wd[2];
				end
				default:
					;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// checks
	//----------------------------------------------------------------------
	// panel pins move one field per bus write
	assert property (@(posedge iSCLK) disable iff (iSRST)
		$countones({$changed(mcuBus.dq), $changed(mcuBus.wrx), $changed(mcuBus.dcx),
			$changed(mcuBus.rdx), $changed(mcuBus.csx), $changed(mcuBus.rst),
			$changed(mcuBus.im), $changed(mcuBus.gate),
			$changed(mcuBus.converterRst)}) <= 1)
		else $error("more than one mcu field changed in a cycle");

endmodule

`default_nettype wire

//--- hdl/CsrReadMux.sv
// registered read data select over the control registers
// and the status inputs from the video side
`default_nettype none
`include "VideoTxCsr_consts.svh"

module CsrReadMux
(
	input	wire						iSCLK,
	input	wire						iSRST,
	input	wire CsrMapPkg::csrOfsE		readSel,
	input	wire VideoCtrlPkg::dmaCtrlT	dmaCtrl,
	input	wire						vsgRst,
	input	wire VideoCtrlPkg::mcuBusT	mcuBus,
	input	wire VideoCtrlPkg::mapSizeT	mapSize,
	input	wire VideoCtrlPkg::sceneCtrlT	sceneCtrl,
	input	wire						iSceneAlphaMax,
	input	wire						iSceneAlphaMin,
	input	wire VideoCtrlPkg::pdpPosT	pdpPos,
	output	logic [`CSR_BUS_W-1:0]		oSUsiRd
);

	// zero extension to the bus word
	typedef logic [`CSR_BUS_W-1:0] rdWordT;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oSUsiRd <= '0;
		else
		begin
			case (readSel)
				CsrMapPkg::OFS_DMA_EN:			oSUsiRd <= rdWordT'(dmaCtrl.enable);
				CsrMapPkg::OFS_DMA_CYC:			oSUsiRd <= rdWordT'(dmaCtrl.cycleEnable);
				CsrMapPkg::OFS_DMA_START:		oSUsiRd <= rdWordT'(dmaCtrl.adrsStart);
				CsrMapPkg::OFS_DMA_END:			oSUsiRd <= rdWordT'(dmaCtrl.adrsEnd);
				CsrMapPkg::OFS_DMA_ADD:			oSUsiRd <= rdWordT'(dmaCtrl.adrsAdd);
				CsrMapPkg::OFS_VSG_RST:			oSUsiRd <= rdWordT'(vsgRst);
				// panel bus
				CsrMapPkg::OFS_MCU_DQ:			oSUsiRd <= rdWordT'(mcuBus.dq);
				CsrMapPkg::OFS_MCU_WRX:			oSUsiRd <= rdWordT'(mcuBus.wrx);
				CsrMapPkg::OFS_MCU_DCX:			oSUsiRd <= rdWordT'(mcuBus.dcx);
				CsrMapPkg::OFS_MCU_RDX:			oSUsiRd <= rdWordT'(mcuBus.rdx);
				CsrMapPkg::OFS_MCU_CSX:			oSUsiRd <= rdWordT'(mcuBus.csx);
				CsrMapPkg::OFS_MCU_RST:			oSUsiRd <= rdWordT'(mcuBus.rst);
				CsrMapPkg::OFS_MCU_IM:			oSUsiRd <= rdWordT'(mcuBus.im);
				CsrMapPkg::OFS_MCU_GATE:		oSUsiRd <= rdWordT'(mcuBus.gate);
				CsrMapPkg::OFS_MCU_CONV_RST:	oSUsiRd <= rdWordT'(mcuBus.converterRst);
				CsrMapPkg::OFS_MAP:
					oSUsiRd <= rdWordT'({mapSize.xSize, mapSize.ySize});	// x high byte
				// scene fader
				CsrMapPkg::OFS_SCN_COLOR:		oSUsiRd <= rdWordT'(sceneCtrl.color);
				CsrMapPkg::OFS_SCN_TIM:			oSUsiRd <= rdWordT'(sceneCtrl.frameTiming);
				CsrMapPkg::OFS_SCN_FLAGS:
					oSUsiRd <= rdWordT'({sceneCtrl.rst, sceneCtrl.subEn, sceneCtrl.addEn});
				CsrMapPkg::OFS_SCN_ALPHA:
					oSUsiRd <= rdWordT'({iSceneAlphaMax, iSceneAlphaMin});
				CsrMapPkg::OFS_PDP_H:			oSUsiRd <= rdWordT'(pdpPos.hpos);
				CsrMapPkg::OFS_PDP_V:			oSUsiRd <= rdWordT'(pdpPos.vpos);
				default:
					oSUsiRd <= '0;	// unmapped reads as zero
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/VideoTxCsr.sv
// video TX control and status register block
// decode, DMA and video register banks, read data mux
`default_nettype none
`include "VideoTxCsr_consts.svh"

module VideoTxCsr
(
	input	wire						iSCLK,
	input	wire						iSRST,
	// slave bus
	input	wire [`CSR_BUS_W-1:0]		iSUsiAdrs,
	input	wire [`CSR_BUS_W-1:0]		iSUsiWd,
	output	logic [`CSR_BUS_W-1:0]		oSUsiRd,
	// dma
	output	VideoCtrlPkg::dmaCtrlT		dmaCtrl,
	input	wire						iDmaDone,
	// video side
	output	logic						vsgRst,
	output	VideoCtrlPkg::mcuBusT		mcuBus,
	output	VideoCtrlPkg::mapSizeT		mapSize,
	output	VideoCtrlPkg::sceneCtrlT	sceneCtrl,
	input	wire						iSceneAlphaMax,
	input	wire						iSceneAlphaMin,
	input	wire VideoCtrlPkg::pdpPosT	pdpPos
);

	CsrMapPkg::csrAccessT	csrAccess;
	CsrMapPkg::csrOfsE		readSel;

	//----------------------------------------------------------------------
	// address decode
	//----------------------------------------------------------------------
	CsrAdrsDecode CsrAdrsDecode_inst
	(
		.iSUsiAdrs	(iSUsiAdrs),
		.iSUsiWd	(iSUsiWd),
		.csrAccess	(csrAccess),
		.readSel	(readSel)
	);

	//----------------------------------------------------------------------
	// register banks
	//----------------------------------------------------------------------
	DmaCsrRegs DmaCsrRegs_inst
	(
		.iSCLK		(iSCLK),
		.iSRST		(iSRST),
		.csrAccess	(csrAccess),
		.iDmaDone	(iDmaDone),
		.dmaCtrl	(dmaCtrl)
	);

	VideoCsrRegs VideoCsrRegs_inst
	(
		.iSCLK		(iSCLK),
		.iSRST		(iSRST),
		.csrAccess	(csrAccess),
		.vsgRst		(vsgRst),
		.mcuBus		(mcuBus),
		.mapSize	(mapSize),
		.sceneCtrl	(sceneCtrl)
	);

	// one cycle read latency
	CsrReadMux CsrReadMux_inst
	(
		.iSCLK			(iSCLK),
		.iSRST			(iSRST),
		.readSel		(readSel),
		.dmaCtrl		(dmaCtrl),
		.vsgRst			(vsgRst),
		.mcuBus			(mcuBus),
		.mapSize		(mapSize),
		.sceneCtrl		(sceneCtrl),
		.iSceneAlphaMax	(iSceneAlphaMax),
		.iSceneAlphaMin	(iSceneAlphaMin),
		.pdpPos			(pdpPos),
		.oSUsiRd		(oSUsiRd)
	);

endmodule

`default_nettype wire

//--- dv/VideoTxCsrTb.sv
// testbench for the video TX CSR block
// file driven bus accesses with LFSR data, read back and struct output checks
`default_nettype none
`include "VideoTxCsr_consts.svh"

module VideoTxCsrTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DONE_TIMEOUT	= 16;
	localparam int MAX_LINES	= 500;

	logic						iSCLK;
	logic						iSRST;
	logic [`CSR_BUS_W-1:0]		iSUsiAdrs;
	logic [`CSR_BUS_W-1:0]		iSUsiWd;
	logic [`CSR_BUS_W-1:0]		oSUsiRd;
	logic						iDmaDone;
	logic						iSceneAlphaMax;
	logic						iSceneAlphaMin;
	VideoCtrlPkg::pdpPosT		pdpPos;
	VideoCtrlPkg::dmaCtrlT		dmaCtrl;
	logic						vsgRst;
	VideoCtrlPkg::mcuBusT		mcuBus;
	VideoCtrlPkg::mapSizeT		mapSize;
	VideoCtrlPkg::sceneCtrlT	sceneCtrl;

	logic [31:0]	lfsr;
	logic [31:0]	lastRand;
	int				errCount;
	int				timeoutCount;
	int				checkCount;

	VideoTxCsr VideoTxCsr_inst
	(
		.iSCLK			(iSCLK),
		.iSRST			(iSRST),
		.iSUsiAdrs		(iSUsiAdrs),
		.iSUsiWd		(iSUsiWd),
		.oSUsiRd		(oSUsiRd),
		.dmaCtrl		(dmaCtrl),
		.iDmaDone		(iDmaDone),
		.vsgRst			(vsgRst),
		.mcuBus			(mcuBus),
		.mapSize		(mapSize),
		.sceneCtrl		(sceneCtrl),
		.iSceneAlphaMax	(iSceneAlphaMax),
		.iSceneAlphaMin	(iSceneAlphaMin),
		.pdpPos			(pdpPos)
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #5 iSCLK = ~iSCLK;
	end

	//----------------------------------------------------------------------
	// helpers
	//----------------------------------------------------------------------
	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		lfsrStep = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic drawRandom(output logic [31:0] val);
		val = '0;
		for (int i = 0; i < 32; i++)
		begin
			val = {val[30:0], lfsr[0]};	// one step per bit
			lfsr = lfsrStep(lfsr);
		end
	endtask

	function automatic logic [31:0] fieldMask(input logic [15:0] ofs);
		case (ofs)
			16'h004, 16'h008, 16'h020, 16'h051, 16'h052, 16'h053, 16'h054,
			16'h055, 16'h057, 16'h058:	fieldMask = 32'h1;
			16'h00c, 16'h010, 16'h014:	fieldMask = 32'({`DMA_ADRS_W{1'b1}});
			16'h050:	fieldMask = 32'({`MCU_DQ_W{1'b1}});
			16'h056:	fieldMask = 32'({`MCU_IM_W{1'b1}});
			16'h100:	fieldMask = 32'hffff;	// x and y bytes
			16'h300:	fieldMask = 32'({`COLOR_W{1'b1}});
			16'h301:	fieldMask = 32'({`SCENE_TIM_W{1'b1}});
			16'h302:	fieldMask = 32'h7;
			16'h303:	fieldMask = 32'h3;
			16'h400:	fieldMask = 32'({`HPOS_W{1'b1}});
			16'h401:	fieldMask = 32'({`VPOS_W{1'b1}});
			default:	fieldMask = '0;
		endcase
	endfunction

	// control value seen on the struct outputs, bit 32 marks a control offset
	function automatic logic [32:0] structField(input logic [15:0] ofs);
		logic [31:0]	v;
		logic			hit;
		hit = 1'b1;
		case (ofs)
			16'h004:	v = 32'(dmaCtrl.enable);
			16'h008:	v = 32'(dmaCtrl.cycleEnable);
			16'h00c:	v = 32'(dmaCtrl.adrsStart);
			16'h010:	v = 32'(dmaCtrl.adrsEnd);
			16'h014:	v = 32'(dmaCtrl.adrsAdd);
			16'h020:	v = 32'(vsgRst);
			16'h050:	v = 32'(mcuBus.dq);
			16'h051:	v = 32'(mcuBus.wrx);
			16'h052:	v = 32'(mcuBus.dcx);
			16'h053:	v = 32'(mcuBus.rdx);
			16'h054:	v = 32'(mcuBus.csx);
			16'h055:	v = 32'(mcuBus.rst);
			16'h056:	v = 32'(mcuBus.im);
			16'h057:	v = 32'(mcuBus.gate);
			16'h058:	v = 32'(mcuBus.converterRst);
			16'h100:	v = 32'({mapSize.xSize, mapSize.ySize});
			16'h300:	v = 32'(sceneCtrl.color);
			16'h301:	v = 32'(sceneCtrl.frameTiming);
			16'h302:	v = 32'({sceneCtrl.rst, sceneCtrl.subEn, sceneCtrl.addEn});
			default:
			begin
				v = '0;
				hit = 1'b0;
			end
		endcase
		structField = {hit, v};
	endfunction

	function automatic logic [31:0] busAdrs(input logic [15:0] ofs, input logic [7:0] blk,
		input logic stb);
		busAdrs = '0;
		busAdrs[`CSR_OFS_W-1:0] = ofs;
		busAdrs[`CSR_BLK_HI:`CSR_BLK_LO] = blk;
		busAdrs[`CSR_WSTB_BIT] = stb;
	endfunction

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
		checkCount++;
		assert (got === exp)
		else
		begin
			errCount++;
			$display("[FAIL] %0t %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	//----------------------------------------------------------------------
	// stimulus
	//----------------------------------------------------------------------
	initial
	begin
		int				fd;
		int				lineNo;
		int				nField;
		int				waitCnt;
		string			line;
		string			op;
		string			dataTok;
		string			expTok;
		logic [15:0]	ofs;
		logic [7:0]		blk;
		logic			stb;
		logic [31:0]	data;
		logic [31:0]	exp;
		logic [32:0]	field;
		bit				abort;

		errCount = 0;
		timeoutCount = 0;
		checkCount = 0;
		lineNo = 0;
		abort = 1'b0;
		exp = '0;
		lastRand = '0;
		lfsr = 32'h6f19;
		iSRST <= 1'b1;
		iSUsiAdrs <= '0;
		iSUsiWd <= '0;
		iDmaDone <= 1'b0;
		iSceneAlphaMax <= 1'b0;
		iSceneAlphaMin <= 1'b0;
		pdpPos <= '0;
		repeat (10) @(posedge iSCLK);
		iSRST <= 1'b0;

		fd = $fopen("dv/csr_tests.txt", "r");
		if (fd == 0)
		begin
			errCount++;
			$display("could not open the test data file dv/csr_tests.txt");
		end
		while (fd != 0 && !abort && !$feof(fd) && lineNo < MAX_LINES)
		begin
			line = "";
			void'($fgets(line, fd));
			lineNo++;
			nField = $sscanf(line, "%s %h %h %h %s %s", op, ofs, blk, stb, dataTok, expTok);
			if (nField == 6)	// comment and blank lines fall out here
			begin
				data = '0;
				if (dataTok == "R")
				begin
					drawRandom(lastRand);
					data = lastRand;
				end
				else if (dataTok != "-")
					void'($sscanf(dataTok, "%h", data));
				if (expTok == "R")
					exp = lastRand & fieldMask(ofs);
				else if (expTok != "-")
					void'($sscanf(expTok, "%h", exp));

				case (op)
					"W":
					begin
						@(posedge iSCLK);
						iSUsiAdrs <= busAdrs(ofs, blk, stb);
						iSUsiWd <= data;
						@(posedge iSCLK);
						iSUsiAdrs <= '0;
					end
					"R":
					begin
						@(posedge iSCLK);
						iSUsiAdrs <= busAdrs(ofs, blk, 1'b0);
						@(posedge iSCLK);
						iSUsiAdrs <= '0;
						@(negedge iSCLK);	// read word registered one cycle later
						checkValue(oSUsiRd, exp, $sformatf("read of offset %h", ofs));
						field = structField(ofs);
						if (field[32])
							checkValue(field[31:0], exp, $sformatf("struct field %h", ofs));
					end
					"D":
					begin
						@(posedge iSCLK);
						iDmaDone <= 1'b1;
						iSUsiAdrs <= busAdrs(ofs, blk, stb);
						iSUsiWd <= data;
						@(posedge iSCLK);
						iDmaDone <= 1'b0;
						iSUsiAdrs <= '0;
						waitCnt = 0;
						@(negedge iSCLK);
						while (dmaCtrl.enable !== exp[0] && waitCnt < DONE_TIMEOUT)
						begin
							@(negedge iSCLK);
							waitCnt++;
						end
						if (dmaCtrl.enable !== exp[0])
						begin
							timeoutCount++;
							abort = 1'b1;
							$display("timed out at %0t waiting for dma enable to become %0d",
								$time, exp[0]);
						end
					end
					"S":
					begin
						@(posedge iSCLK);
						case (ofs)
							16'h303:
							begin
								iSceneAlphaMax <= data[1];
								iSceneAlphaMin <= data[0];
							end
							16'h400:	pdpPos.hpos <= data[`HPOS_W-1:0];
							default:	pdpPos.vpos <= data[`VPOS_W-1:0];
						endcase
					end
					default:
					begin
						errCount++;
						$display("unknown operation %s on line %0d of the test data", op, lineNo);
					end
				endcase
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("checks %0d, value errors %0d, timeouts %0d", checkCount, errCount,
			timeoutCount);
		if (errCount == 0 && timeoutCount == 0 && checkCount > 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/csr_tests.txt
# op ofs blk stb data expected, all hex, R draws from the LFSR, - is unused
# W write, R read and check, D dma done with optional write, S drive a status input
R 004 04 0 - 0
R 008 04 0 - 0
R 00c 04 0 - 0
R 010 04 0 - 7ffff
R 014 04 0 - 0
R 020 04 0 - 1
R 050 04 0 - 0
R 051 04 0 - 0
R 052 04 0 - 0
R 053 04 0 - 0
R 054 04 0 - 1
R 055 04 0 - 0
R 056 04 0 - 0
R 057 04 0 - 1
R 058 04 0 - 1
R 100 04 0 - 1e11
R 300 04 0 - 0
R 301 04 0 - 0
R 302 04 0 - 4
R 303 04 0 - 0
R 400 04 0 - 0
R 401 04 0 - 0
W 100 04 0 1234 -
R 100 04 0 - 1e11
W 100 05 1 1234 -
R 100 04 0 - 1e11
W 00c 04 1 R -
R 00c 04 0 - R
W 050 04 1 R -
R 050 04 0 - R
W 100 04 1 R -
R 100 04 0 - R
W 300 04 1 R -
R 300 04 0 - R
W 301 04 1 R -
R 301 04 0 - R
W 302 04 1 3 -
R 302 04 0 - 3
W 008 04 1 1 -
W 004 04 1 1 -
D 000 04 0 - 1
W 008 04 1 0 -
D 000 04 0 - 0
W 004 04 1 1 -
D 004 04 1 1 0
R 004 04 0 - 0
S 303 04 0 2 -
R 303 04 0 - 2
S 400 04 0 5a5 -
R 400 04 0 - 5a5
S 401 04 0 3ff -
R 401 04 0 - 3ff
R 018 04 0 - 0

//--- files.f
+incdir+hdl
hdl/CsrMapPkg.sv
hdl/VideoCtrlPkg.sv
hdl/CsrAdrsDecode.sv
hdl/DmaCsrRegs.sv
hdl/VideoCsrRegs.sv
hdl/CsrReadMux.sv
hdl/VideoTxCsr.sv
dv/VideoTxCsrTb.sv
